// ==== files.f ====
+incdir+hw
hw/median_pkg.sv
hw/sample_delay_line.sv
hw/rank_cell.sv
hw/rank_array.sv
hw/median_out_stage.sv
hw/median_filter_top.sv
dv/median_filter_tb.sv

// ==== Bender.yml ====
package:
  name: median_filter

sources:
  - include_dirs:
      - hw
    files:
      - hw/median_pkg.sv
      - hw/sample_delay_line.sv
      - hw/rank_cell.sv
      - hw/rank_array.sv
      - hw/median_out_stage.sv
      - hw/median_filter_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - dv/median_filter_tb.sv

// ==== dv/median_filter_tb.sv ====
// testbench for the running median filter with reference model, compare process and watchdog
`include "median_config.svh"

module median_filter_tb import median_pkg::*; ();

	localparam int DRIVE_DLY = 2;
	localparam int CLK_PER   = 20;
	localparam int FILL_IDLE = 5;
	localparam int STREAM_N  = 300;
	localparam int GAP_CYC   = 200;
	localparam int DUP_N     = 140;
	localparam int DRAIN_CYC = 8;
	// one sample or one idle slot per cycle in every phase
	localparam int SAMPLES   = `MF_WIN + STREAM_N + GAP_CYC + DUP_N;
	localparam int IDLE_CYC  = 2 + FILL_IDLE + 4 * (DRAIN_CYC + 4);
	localparam int WATCHDOG_T = (SAMPLES + IDLE_CYC + 10) * CLK_PER;

	logic    clk;
	logic    RST;
	logic    in_en;
	sample_t din;
	sample_t dout;
	logic    out_valid;

	integer  seed = 8;
	string   test_name = "reset";
	sample_t model_hist [0:`MF_WIN-1];
	int      model_cnt = 0;
	sample_t exp_q [$];
	sample_t exp_val;
	int      result_cnt = 0;
	int      base_cnt;
	int      accepted;

	median_filter_top dut_i (
		.clk       (clk),
		.RST       (RST),
		.din       (din),
		.in_en     (in_en),
		.dout      (dout),
		.out_valid (out_valid)
	);

	always #(CLK_PER / 2) clk = ~clk;

	task automatic fail_run();
		$display("CHECKS FAILED");
		$fatal(1, "stopped at first failure");
	endtask

	task automatic check_sample(input string name, input sample_t exp, input sample_t act);
		if (act !== exp) begin
			$display("Error: test %s expected %0d actual %0d", name, exp, act);
			fail_run();
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("Error: test %s expected %b actual %b", name, exp, act);
			fail_run();
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (act != exp) begin
			$display("Error: test %s expected %0d results actual %0d", name, exp, act);
			fail_run();
		end
	endtask

	// sorted copy of the model window, middle element
	function automatic sample_t ref_median();
		sample_t srt [0:`MF_WIN-1];
		sample_t tmp;
		for (int i = 0; i < `MF_WIN; i++) begin
			srt[i] = model_hist[i];
		end
		for (int i = 0; i < `MF_WIN - 1; i++) begin
			for (int j = 0; j < `MF_WIN - 1 - i; j++) begin
				if (srt[j] > srt[j+1]) begin
					tmp = srt[j];
					srt[j] = srt[j+1];
					srt[j+1] = tmp;
				end
			end
		end
		return srt[`MF_MID];
	endfunction

	// oldest sample drops out at index 0
	task automatic model_push(input sample_t s);
		for (int i = 0; i < `MF_WIN - 1; i++) begin
			model_hist[i] = model_hist[i+1];
		end
		model_hist[`MF_WIN-1] = s;
		model_cnt++;
		if (model_cnt >= `MF_WIN) begin
			exp_q.push_back(ref_median());
		end
	endtask

	task automatic drive_sample(input sample_t s);
		@(posedge clk);
		#DRIVE_DLY;
		din = s;
		in_en = 1'b1;
		model_push(s);
	endtask

	task automatic drive_idle();
		@(posedge clk);
		#DRIVE_DLY;
		in_en = 1'b0;
	endtask

	// wait for pending results within the output latency, then a few quiet cycles
	task automatic drain_results();
		int waited;
		waited = 0;
		drive_idle();
		while (exp_q.size() != 0 && waited < DRAIN_CYC) begin
			@(posedge clk);
			waited++;
		end
		repeat (3) @(posedge clk);
	endtask

	// every pulse must match the next model result
	always @(negedge clk) begin
		if (!RST && out_valid) begin
			if (exp_q.size() == 0) begin
				$display("unexpected result in test %s with no sample waiting for it",
					test_name);
				fail_run();
			end else begin
				exp_val = exp_q.pop_front();
				check_sample(test_name, exp_val, dout);
				result_cnt++;
			end
		end
	end

	initial begin
		#(WATCHDOG_T);
		$display("timeout: run did not finish within %0d time units", WATCHDOG_T);
		fail_run();
	end

	initial begin
		clk = 1'b0;
		RST = 1'b1;
		in_en = 1'b0;
		din = '0;
		for (int i = 0; i < `MF_WIN; i++) begin
			model_hist[i] = sample_t'(`MF_PAD);
		end

		// reset state
		@(posedge clk);
		@(negedge clk);
		check_flag("reset", 1'b0, out_valid);
		check_sample("reset", '0, dout);
		@(posedge clk);
		#DRIVE_DLY;
		RST = 1'b0;
		@(negedge clk);
		check_flag("reset_release", 1'b0, out_valid);
		check_sample("reset_release", '0, dout);

		// ramp fill, nothing before the 49th sample
		test_name = "fill";
		base_cnt = result_cnt;
		for (int i = 0; i < `MF_WIN - 1; i++) begin
			drive_sample(sample_t'(i * 5));
		end
		repeat (FILL_IDLE) drive_idle();
		drive_sample(sample_t'((`MF_WIN - 1) * 5));
		drain_results();
		check_count("fill", 1, result_cnt - base_cnt);

		// back to back random stream
		test_name = "stream";
		base_cnt = result_cnt;
		for (int i = 0; i < STREAM_N; i++) begin
			drive_sample(sample_t'($random(seed)));
		end
		drain_results();
		check_count("stream", STREAM_N, result_cnt - base_cnt);

		// random stream with idle slots
		test_name = "gaps";
		base_cnt = result_cnt;
		accepted = 0;
		for (int i = 0; i < GAP_CYC; i++) begin
			if (($random(seed) & 3) == 0) begin
				drive_idle();
			end else begin
				drive_sample(sample_t'($random(seed)));
				accepted++;
			end
		end
		drain_results();
		check_count("gaps", accepted, result_cnt - base_cnt);

		// constant run, alternating pair, then a run at the pad value
		test_name = "duplicates";
		base_cnt = result_cnt;
		for (int i = 0; i < 60; i++) begin
			drive_sample(sample_t'(77));
		end
		for (int i = 0; i < 60; i++) begin
			drive_sample((i % 2 == 0) ? sample_t'(10) : sample_t'(200));
		end
		for (int i = 0; i < 20; i++) begin
			drive_sample(sample_t'(`MF_PAD));
		end
		drain_results();
		check_count("duplicates", DUP_N, result_cnt - base_cnt);

		if (exp_q.size() == 0) begin
			$display("ALL CHECKS PASSED");
			$finish;
		end else begin
			$display("missing %0d results at end of run", exp_q.size());
			fail_run();
		end
	end

endmodule

// ==== hw/median_filter_top.sv ====
// top level of the running median filter with delay line, rank array and output stage
`include "median_config.svh"

module median_filter_top import median_pkg::*; (
	input  logic    clk,
	input  logic    RST,
	input  sample_t din,
	input  logic    in_en,
	output sample_t dout,
	output logic    out_valid
);

	sample_t evicted;
	sample_t median;
	logic    win_full;

	// history of the window, hands back the sample to delete
	sample_delay_line delay_i (
		.clk      (clk),
		.RST      (RST),
		.in_en    (in_en),
		.din      (din),
		.evicted  (evicted),
		.win_full (win_full)
	);

	// sorted window, new sample in and oldest out on the same update
	rank_array rank_i (
		.clk    (clk),
		.RST    (RST),
		.in_en  (in_en),
		.ins    (din),
		.del    (evicted),
		.median (median)
	);

	// results only once the window is full
	median_out_stage out_i (
		.clk       (clk),
		.RST       (RST),
		.in_en     (in_en),
		.win_full  (win_full),
		.median    (median),
		.dout      (dout),
		.out_valid (out_valid)
	);

endmodule

// ==== hw/median_out_stage.sv ====
// output stage registering the middle rank and pulsing out_valid
`include "median_config.svh"

module median_out_stage import median_pkg::*; (
	input  logic    clk,
	input  logic    RST,
	input  logic    in_en,
	input  logic    win_full,
	input  sample_t median,
	output sample_t dout,
	output logic    out_valid
);

	// sample accepted, chain inputs registered this cycle
	logic acc_q;
	// chain updating with a sample of a full window
	logic upd_q;

	always_ff @(posedge clk or posedge RST) begin
		if (RST) begin
			acc_q     <= 1'b0;
			upd_q     <= 1'b0;
			out_valid <= 1'b0;
			dout      <= '0;
		end else begin
			acc_q <= in_en;
			// win_full is looked at one edge late,
			// so the sample that completes the fill also counts
			upd_q     <= acc_q & win_full;
			out_valid <= upd_q;
			if (upd_q) begin
				dout <= median;
			end
		end
	end

	// each result traces back to exactly one accepted sample
	one_result_a: assert property (@(posedge clk) disable iff (RST)
		out_valid |-> $past(in_en, 3));

endmodule

// ==== hw/rank_array.sv ====
// rank array of compare-and-shift cells keeping the window in ascending order
`include "median_config.svh"

module rank_array import median_pkg::*; (
	input  logic    clk,
	input  logic    RST,
	input  logic    in_en,
	input  sample_t ins,
	input  sample_t del,
	output sample_t median
);

	localparam sample_t PAD = sample_t'(`MF_PAD);

	sample_t ins_q;
	sample_t del_q;
	sample_t cell_val [0:`MF_WIN-1];
	sample_t prev_val [0:`MF_WIN-1];
	sample_t next_val [0:`MF_WIN-1];

	// insert/delete pair for the chain, one edge after acceptance
	// an equal pad pair means no cell moves
	always_ff @(posedge clk or posedge RST) begin
		if (RST) begin
			ins_q <= PAD;
			del_q <= PAD;
		end else if (in_en) begin
			ins_q <= ins;
			del_q <= del;
		end else begin
			ins_q <= PAD;
			del_q <= PAD;
		end
	end

	for (genvar g = 0; g < `MF_WIN; g++) begin : g_cell
		// lower neighbour, zero below the first cell
		if (g == 0) begin : g_first
			assign prev_val[g] = '0;
		end else begin : g_prev
			assign prev_val[g] = cell_val[g-1];
		end

		// upper neighbour, pad above the last cell
		if (g == `MF_WIN - 1) begin : g_last
			assign next_val[g] = PAD;
		end else begin : g_next
			assign next_val[g] = cell_val[g+1];

			// chain stays sorted across every update
			sorted_a: assert property (@(posedge clk) disable iff (RST)
				cell_val[g] <= cell_val[g+1]);
		end

		rank_cell cell_i (
			.clk   (clk),
			.RST   (RST),
			.ins   (ins_q),
			.del   (del_q),
			.prev  (prev_val[g]),
			.next  (next_val[g]),
			.value (cell_val[g])
		);
	end

	// middle rank of the sorted window
	assign median = cell_val[`MF_MID];

endmodule

// ==== hw/rank_cell.sv ====
// one compare-and-shift cell of the sorted rank chain
`include "median_config.svh"

module rank_cell import median_pkg::*; (
	input  logic    clk,
	input  logic    RST,
	input  sample_t ins,
	input  sample_t del,
	input  sample_t prev,
	input  sample_t next,
	output sample_t value
);

	logic    ins_below;
	logic    ins_above;
	logic    in_low_band;
	logic    in_high_band;
	sample_t value_d;

	// direction of the move follows the insert/delete order
	assign ins_below = (ins < del);
	assign ins_above = (ins > del);

	// cells between ins and del are the ones that shift
	assign in_low_band  = (value > ins) && (value <= del);
	assign in_high_band = (value < ins) && (value >= del);

	always_comb begin
		value_d = value;
		if (ins_below) begin
			if (in_low_band) begin
				// shift up from below, or take the new sample
				if (prev > ins) begin
					value_d = prev;
				end else begin
					value_d = ins;
				end
			end
		end else if (ins_above) begin
			if (in_high_band) begin
				// shift down from above, or take the new sample
				if (next < ins) begin
					value_d = next;
				end else begin
					value_d = ins;
				end
			end
		end
		// equal ins and del leaves the cell alone
	end

	always_ff @(posedge clk or posedge RST) begin
		if (RST) begin
			value <= sample_t'(`MF_PAD);
		end else begin
			value <= value_d;
		end
	end

endmodule

// ==== hw/sample_delay_line.sv ====
// sample delay line holding the last window of samples, evicted sample and fill flag
`include "median_config.svh"

module sample_delay_line import median_pkg::*; (
	input  logic    clk,
	input  logic    RST,
	input  logic    in_en,
	input  sample_t din,
	output sample_t evicted,
	output logic    win_full
);

	localparam rank_idx_t LAST_IDX = rank_idx_t'(`MF_WIN - 1);
	localparam fill_cnt_t FULL_CNT = fill_cnt_t'(`MF_WIN);

	sample_t   hist [0:`MF_WIN-1];
	rank_idx_t wr_ptr;
	rank_idx_t wr_ptr_nxt;
	fill_cnt_t fill_cnt;

	// oldest entry sits at the write pointer
	assign evicted  = hist[wr_ptr];
	assign win_full = (fill_cnt == FULL_CNT);

	// wrap at the end of the window
	always_comb begin
		if (wr_ptr == LAST_IDX) begin
			wr_ptr_nxt = '0;
		end else begin
			wr_ptr_nxt = rank_idx_t'(wr_ptr + 1'b1);
		end
	end

	always_ff @(posedge clk or posedge RST) begin
		if (RST) begin
			wr_ptr   <= '0;
			fill_cnt <= '0;
		end else if (in_en) begin
			wr_ptr <= wr_ptr_nxt;
			// stop counting once the window holds only real samples
			if (!win_full) begin
				fill_cnt <= fill_cnt_t'(fill_cnt + 1'b1);
			end
		end
	end

	// starts out full of pad samples, same as the rank chain
	always_ff @(posedge clk or posedge RST) begin
		if (RST) begin
			for (int i = 0; i < `MF_WIN; i++) begin
				hist[i] <= sample_t'(`MF_PAD);
			end
		end else if (in_en) begin
			// the entry being replaced is the one the chain deletes
			hist[wr_ptr] <= din;
		end
	end

	// pointer never leaves the history
	ptr_in_range_a: assert property (@(posedge clk) disable iff (RST)
		wr_ptr <= LAST_IDX);

endmodule

// ==== hw/median_pkg.sv ====
// sample, rank index and fill count types of the running median filter
`include "median_config.svh"

package median_pkg;

	// one sample of the input stream
	typedef logic [`MF_DATA_W-1:0] sample_t;

	// position in the history or in the sorted chain
	typedef logic [5:0] rank_idx_t;

	// accepted samples so far, saturates at the window length
	typedef logic [5:0] fill_cnt_t;

endpackage

// ==== hw/median_config.svh ====
// data width, window length, median index and pad value of the running median filter
`ifndef MEDIAN_CONFIG_SVH
`define MEDIAN_CONFIG_SVH

// width of one stream sample
`define MF_DATA_W 8

// number of samples in the sliding window
`define MF_WIN 49

// rank of the median inside the sorted window
`define MF_MID 24

// fill value of the history and the chain after reset,
// also the boundary seen above the last cell
`define MF_PAD 255

`endif
